// ==== project.f ====
source/clic_pkg.sv
source/csr_reg.sv
source/csr_timer.sv
source/epc_stack.sv
source/prio_select.sv
source/clic.sv
verification/clic_checker.sv
verification/clic_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the clic testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module clic_tb -f project.f -o clic_sim

# the run result is taken from the printed messages
output=$(./obj_dir/clic_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
  exit 0
else
  exit 1
fi

// ==== source/clic.sv ====
// clic is the core-local interrupt controller with take, tail-chain and return
`timescale 1ns/1ps
`default_nettype none

module clic (
  input  logic                 clk,
  input  logic                 reset,
  input  clic_pkg::csr_req_t   csr_req,
  input  clic_pkg::imem_addr_t pc_in,
  output clic_pkg::word        csr_out,
  output clic_pkg::imem_addr_t int_addr,
  output clic_pkg::pc_sel_t    pc_sel,
  output clic_pkg::prio_t      level_out,
  output logic                 interrupt_out
);
  import clic_pkg::*;

  // vectors are word addresses, two lsbs dropped
  localparam int VecStoreWidth = IMemAddrWidth - 2;

  logic tick;
  word  timer_rd;

  csr_timer u_timer (
    .clk    (clk),
    .reset  (reset),
    .csr_req(csr_req),
    .tick   (tick),
    .rd_data(timer_rd)
  );

  prio_t thresh;
  prio_t thresh_data;
  logic  thresh_we;
  word   thresh_rd;

  csr_reg #(
    .CsrWidth(PrioWidth),
    .Addr    (MIntThreshAddr)
  ) u_thresh (
    .clk     (clk),
    .reset   (reset),
    .csr_req (csr_req),
    .ext_we  (thresh_we),
    .ext_data(thresh_data),
    .value   (thresh),
    .rd_data (thresh_rd)
  );

  logic [VecStoreWidth-1:0] vec_value [VecSize];
  word                      vec_rd    [VecSize];
  entry_t                   entries   [VecSize];
  entry_t                   entry_wdata [VecSize];
  logic                     entry_we  [VecSize];
  word                      entry_rd  [VecSize];

  for (genvar k = 0; k < VecSize; k++) begin : gen_slot
    csr_reg #(
      .CsrWidth(VecStoreWidth),
      .Addr    (VecCsrBase + csr_addr_t'(k))
    ) u_vec (
      .clk     (clk),
      .reset   (reset),
      .csr_req (csr_req),
      .ext_we  (1'b0),
      .ext_data('0),
      .value   (vec_value[k]),
      .rd_data (vec_rd[k])
    );

    csr_reg #(
      .CsrWidth($bits(entry_t)),
      .Addr    (EntryCsrBase + csr_addr_t'(k))
    ) u_entry (
      .clk     (clk),
      .reset   (reset),
      .csr_req (csr_req),
      .ext_we  (entry_we[k]),
      .ext_data(entry_wdata[k]),
      .value   (entries[k]),
      .rd_data (entry_rd[k])
    );
  end

  logic         push;
  logic         pop;
  stack_entry_t push_data;
  stack_entry_t stack_top;

  assign push_data = '{addr: pc_in, prio: thresh};

  epc_stack #(
    .Depth(PrioNum)
  ) u_stack (
    .clk    (clk),
    .reset  (reset),
    .push   (push),
    .pop    (pop),
    .data_in(push_data),
    .top    (stack_top),
    .depth  (level_out)
  );

  logic  found;
  prio_t best_prio;
  vec_t  best_index;

  prio_select u_select (
    .entries   (entries),
    .floor     (thresh),
    .found     (found),
    .best_prio (best_prio),
    .best_index(best_index)
  );

  logic is_ret;
  logic take;
  logic chain;

  assign is_ret = (pc_in == RetMarker);
  assign take   = found && (best_prio > thresh);
  assign chain  = is_ret && found && !take;

  always_comb begin
    push          = 1'b0;
    pop           = 1'b0;
    thresh_we     = 1'b0;
    thresh_data   = best_prio;
    int_addr      = pc_in;
    pc_sel        = PC_NORMAL;
    interrupt_out = 1'b0;
    for (int k = 0; k < VecSize; k++) begin
      entry_we[k]    = 1'b0;
      entry_wdata[k] = entries[k];
    end

    // timer pends slot 0
    if (tick) begin
      entry_we[0]           = 1'b1;
      entry_wdata[0].pended = 1'b1;
    end

    if (take || chain) begin
      int_addr      = {vec_value[best_index], 2'b00};
      pc_sel        = PC_INTERRUPT;
      interrupt_out = 1'b1;
      entry_we[best_index] = 1'b1;
      // a tick arriving while slot 0 is taken stays pending
      entry_wdata[best_index].pended = tick && (best_index == '0);
    end

    if (take) begin
      push      = 1'b1;
      thresh_we = 1'b1;
    end else if (is_ret && !chain) begin
      // return to the interrupted code and restore its threshold
      pop         = 1'b1;
      thresh_we   = 1'b1;
      thresh_data = stack_top.prio;
      int_addr    = stack_top.addr;
      pc_sel      = PC_INTERRUPT;
    end
  end

  word depth_rd;

  assign depth_rd = (csr_req.addr == StackDepthAddr) ? word'(level_out) : '0;

  // unaddressed registers read 0, so a plain OR is the readback mux
  always_comb begin
    csr_out = timer_rd | thresh_rd | depth_rd;
    for (int k = 0; k < VecSize; k++) begin
      csr_out = csr_out | vec_rd[k] | entry_rd[k];
    end
  end

endmodule

`default_nettype wire

// ==== source/clic_pkg.sv ====
// clic package with the shared widths, CSR map, opcodes and request types
`default_nettype none

package clic_pkg;

  // widths and sizes
  localparam int IMemAddrWidth = 16;
  localparam int PrioWidth     = 3;
  localparam int PrioNum       = 8;
  localparam int VecSize       = 8;
  localparam int VecWidth      = $clog2(VecSize);

  typedef logic [31:0]              word;
  typedef logic [11:0]              csr_addr_t;
  typedef logic [IMemAddrWidth-1:0] imem_addr_t;
  typedef logic [PrioWidth-1:0]     prio_t;
  typedef logic [VecWidth-1:0]      vec_t;

  // CSR map
  localparam csr_addr_t TimerAddr      = 12'h400;
  localparam csr_addr_t MIntThreshAddr = 12'h347;
  localparam csr_addr_t StackDepthAddr = 12'h350;
  localparam csr_addr_t VecCsrBase     = 12'hb00;
  localparam csr_addr_t EntryCsrBase   = 12'hb20;

  // funct3 style encoding, bit 2 selects the immediate form
  typedef enum logic [2:0] {
    CSR_RW  = 3'b001,
    CSR_RS  = 3'b010,
    CSR_RC  = 3'b011,
    CSR_RWI = 3'b101,
    CSR_RSI = 3'b110,
    CSR_RCI = 3'b111
  } csr_op_t;

  typedef struct packed {
    logic      enable;
    csr_addr_t addr;
    csr_op_t   op;
    logic [4:0] zimm;
    word       data;
  } csr_req_t;

  // pend bit sits in the lsb so a 5 bit immediate reaches every field
  typedef struct packed {
    prio_t prio;
    logic  enabled;
    logic  pended;
  } entry_t;

  typedef struct packed {
    imem_addr_t addr;
    prio_t      prio;
  } stack_entry_t;

  typedef enum logic {
    PC_NORMAL    = 1'b0,
    PC_INTERRUPT = 1'b1
  } pc_sel_t;

  // pc of all ones marks a return from a handler
  localparam imem_addr_t RetMarker = '1;

endpackage

`default_nettype wire

// ==== source/csr_reg.sv ====
// csr_reg holds one CSR of configurable width, applies CSR ops and an external write
`timescale 1ns/1ps
`default_nettype none

module csr_reg #(
  parameter int                  CsrWidth = 32,
  parameter clic_pkg::csr_addr_t Addr     = 12'h000
) (
  input  logic                 clk,
  input  logic                 reset,
  input  clic_pkg::csr_req_t   csr_req,
  input  logic                 ext_we,
  input  logic [CsrWidth-1:0]  ext_data,
  output logic [CsrWidth-1:0]  value,
  output clic_pkg::word        rd_data
);
  import clic_pkg::*;

  logic hit;
  logic csr_we;
  word  operand;
  word  current;
  word  next_value;

  assign hit = (csr_req.addr == Addr);

  always_comb begin
    operand = csr_req.data;
    if (csr_req.op inside {CSR_RWI, CSR_RSI, CSR_RCI}) begin
      operand = word'(csr_req.zimm);
    end
    current = word'(value);
    csr_we  = csr_req.enable && hit;
    case (csr_req.op)
      CSR_RW, CSR_RWI: next_value = operand;
      CSR_RS, CSR_RSI: next_value = current | operand;
      CSR_RC, CSR_RCI: next_value = current & ~operand;
      default: begin
        next_value = current;
        csr_we     = 1'b0;
      end
    endcase
  end

  // hardware updates take precedence over the core
  always_ff @(posedge clk) begin
    if (reset) begin
      value <= '0;
    end else if (ext_we) begin
      value <= ext_data;
    end else if (csr_we) begin
      value <= next_value[CsrWidth-1:0];
    end
  end

  // zero when not addressed so readbacks can be OR-ed
  assign rd_data = hit ? word'(value) : '0;

endmodule

`default_nettype wire

// ==== source/csr_timer.sv ====
// csr_timer is the period CSR plus a cycle counter that pulses tick for slot 0
`timescale 1ns/1ps
`default_nettype none

module csr_timer (
  input  logic               clk,
  input  logic               reset,
  input  clic_pkg::csr_req_t csr_req,
  output logic               tick,
  output clic_pkg::word      rd_data
);
  import clic_pkg::*;

  word period;
  word count;

  csr_reg #(
    .CsrWidth(32),
    .Addr    (TimerAddr)
  ) u_period (
    .clk     (clk),
    .reset   (reset),
    .csr_req (csr_req),
    .ext_we  (1'b0),
    .ext_data('0),
    .value   (period),
    .rd_data (rd_data)
  );

  // >= so that shrinking the period below the count still fires
  assign tick = (period != '0) && (count >= period);

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (period == '0) begin
      // stopped timer
      count <= '0;
    end else if (tick) begin
      count <= '0;
    end else begin
      count <= count + 32'd1;
    end
  end

endmodule

`default_nettype wire

// ==== source/epc_stack.sv ====
// epc_stack is a LIFO of return address and saved threshold for nested handlers
`timescale 1ns/1ps
`default_nettype none

module epc_stack #(
  parameter int Depth = clic_pkg::PrioNum
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   push,
  input  logic                   pop,
  input  clic_pkg::stack_entry_t data_in,
  output clic_pkg::stack_entry_t top,
  output clic_pkg::prio_t        depth
);
  import clic_pkg::*;

  // every take raises the threshold, so nesting stops at Depth-1 levels
  stack_entry_t mem [Depth-1];

  logic full;
  logic empty;

  assign full  = (depth == prio_t'(Depth - 1));
  assign empty = (depth == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      depth <= '0;
    end else if (push && !full) begin
      depth <= depth + prio_t'(1);
    end else if (pop && !empty) begin
      depth <= depth - prio_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (push && !full) begin
      mem[depth] <= data_in;
    end
  end

  assign top = empty ? '0 : mem[depth - prio_t'(1)];

endmodule

`default_nettype wire

// ==== source/prio_select.sv ====
// prio_select scans the entry table for the best enabled and pended slot
`timescale 1ns/1ps
`default_nettype none

module prio_select (
  input  clic_pkg::entry_t entries [clic_pkg::VecSize],
  input  clic_pkg::prio_t  floor,
  output logic             found,
  output clic_pkg::prio_t  best_prio,
  output clic_pkg::vec_t   best_index
);
  import clic_pkg::*;

  logic eligible [VecSize];

  always_comb begin
    for (int k = 0; k < VecSize; k++) begin
      eligible[k] = entries[k].enabled && entries[k].pended &&
                    (entries[k].prio >= floor);
    end
  end

  // ascending scan with >= lets the higher index win a tie
  always_comb begin
    found      = 1'b0;
    best_prio  = floor;
    best_index = '0;
    for (int k = 0; k < VecSize; k++) begin
      if (eligible[k] && (!found || (entries[k].prio >= best_prio))) begin
        found      = 1'b1;
        best_prio  = entries[k].prio;
        best_index = vec_t'(k);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/clic_checker.sv ====
// clic_checker holds concurrent assertions on the clic decision outputs and nesting level
`timescale 1ns/1ps
`default_nettype none

module clic_checker (
  input logic                 clk,
  input logic                 reset,
  input clic_pkg::imem_addr_t pc_in,
  input clic_pkg::prio_t      level_out,
  input logic                 interrupt_out
);
  import clic_pkg::*;

  // an interrupt outside a return is a take and nests one level deeper
  a_take_nests: assert property (@(posedge clk) disable iff (reset)
    (interrupt_out && (pc_in != RetMarker) && (level_out != prio_t'(PrioNum - 1)))
    |=> (level_out == $past(level_out) + prio_t'(1)))
    else $error("take did not raise the nesting level by one");

  // one push or pop per cycle keeps the level from wrapping
  a_level_step: assert property (@(posedge clk) disable iff (reset)
    (int'(level_out) <= int'($past(level_out)) + 1) &&
    (int'(level_out) >= int'($past(level_out)) - 1))
    else $error("level_out moved by more than one step or wrapped");

  // cleared tables leave nothing to take
  a_quiet_after_reset: assert property (@(posedge clk)
    reset |=> !interrupt_out)
    else $error("interrupt_out high right after reset");

endmodule

bind clic clic_checker u_checker (
  .clk          (clk),
  .reset        (reset),
  .pc_in        (pc_in),
  .level_out    (level_out),
  .interrupt_out(interrupt_out)
);

`default_nettype wire

// ==== verification/clic_tb.sv ====
// clic_tb is the directed testbench for the interrupt controller
`timescale 1ns/1ps
`default_nettype none

module clic_tb;
  import clic_pkg::*;

  // the whole run takes a few hundred cycles
  localparam int TimeoutCycles = 2000;
  localparam int TimerPeriod   = 10;

  logic         clk;
  logic         reset;
  csr_req_t     csr_req;
  imem_addr_t   pc_in;
  word          csr_out;
  imem_addr_t   int_addr;
  pc_sel_t      pc_sel;
  prio_t        level_out;
  logic         interrupt_out;

  integer       seed;
  int           cycles = 0;
  imem_addr_t   outer_pc;
  imem_addr_t   inner_pc;

  clic u_clic (
    .clk          (clk),
    .reset        (reset),
    .csr_req      (csr_req),
    .pc_in        (pc_in),
    .csr_out      (csr_out),
    .int_addr     (int_addr),
    .pc_sel       (pc_sel),
    .level_out    (level_out),
    .interrupt_out(interrupt_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("Simulation failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic report_mismatch(string what, word actual, word expected);
    $display("Fail at time %0t: %s is %h, expected %h", $time, what, actual, expected);
    $display("Simulation failed");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic check_word(word actual, word expected, string what);
    if (actual !== expected) report_mismatch(what, actual, expected);
  endtask

  task automatic check_addr(imem_addr_t actual, imem_addr_t expected, string what);
    if (actual !== expected) report_mismatch(what, word'(actual), word'(expected));
  endtask

  task automatic check_prio(prio_t actual, prio_t expected, string what);
    if (actual !== expected) report_mismatch(what, word'(actual), word'(expected));
  endtask

  task automatic check_sel(pc_sel_t actual, pc_sel_t expected, string what);
    if (actual !== expected) report_mismatch(what, word'(actual), word'(expected));
  endtask

  task automatic check_flag(logic actual, logic expected, string what);
    if (actual !== expected) report_mismatch(what, word'(actual), word'(expected));
  endtask

  task automatic check_decision(imem_addr_t addr, pc_sel_t sel, logic irq, string what);
    check_addr(int_addr, addr, {what, ", int_addr"});
    check_sel(pc_sel, sel, {what, ", pc_sel"});
    check_flag(interrupt_out, irq, {what, ", interrupt_out"});
  endtask

  // write, set or clear the old value as the op says
  function automatic word csr_model(csr_op_t op, word old, word data, logic [4:0] zimm,
                                    word mask);
    word src;
    word res;
    src = data;
    if (op == CSR_RWI || op == CSR_RSI || op == CSR_RCI) src = {27'd0, zimm};
    case (op)
      CSR_RW, CSR_RWI: res = src;
      CSR_RS, CSR_RSI: res = old | src;
      default:         res = old & ~src;
    endcase
    return res & mask;
  endfunction

  function automatic word entry_val(prio_t prio, logic enabled, logic pended);
    return {27'd0, prio, enabled, pended};
  endfunction

  function automatic word random_vec();
    word r;
    r = $random(seed);
    return {18'd0, r[13:0]};
  endfunction

  // word aligned, so never the return marker
  function automatic imem_addr_t random_pc();
    word r;
    r = $random(seed);
    return {r[15:2], 2'b00};
  endfunction

  function automatic imem_addr_t vec_target(word vec);
    return {vec[13:0], 2'b00};
  endfunction

  task automatic csr_access(csr_op_t op, csr_addr_t addr, word data, logic [4:0] zimm);
    @(posedge clk);
    csr_req <= '{enable: 1'b1, addr: addr, op: op, zimm: zimm, data: data};
    @(posedge clk);
    csr_req.enable <= 1'b0;
  endtask

  task automatic csr_read(csr_addr_t addr, output word rd);
    @(posedge clk);
    csr_req <= '{enable: 1'b0, addr: addr, op: CSR_RW, zimm: 5'd0, data: 32'd0};
    @(negedge clk);
    rd = csr_out;
  endtask

  task automatic drive_pc(imem_addr_t pc);
    @(posedge clk);
    pc_in <= pc;
    @(negedge clk);
  endtask

  // forbid keeps bits such as an entry enable out of the stimulus
  task automatic exercise_csr(csr_addr_t addr, word mask, word forbid, string what);
    csr_op_t    ops [6];
    word        model;
    word        data;
    word        rnd;
    word        rd;
    logic [4:0] zimm;
    ops = '{CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};
    csr_read(addr, model);
    foreach (ops[i]) begin
      data = $random(seed) & ~forbid;
      rnd  = $random(seed);
      zimm = rnd[4:0] & ~forbid[4:0];
      model = csr_model(ops[i], model, data, zimm, mask);
      csr_access(ops[i], addr, data, zimm);
      csr_read(addr, rd);
      check_word(rd, model, $sformatf("%s after %s", what, ops[i].name()));
    end
  endtask

  task automatic test_csr_ops();
    word rd;
    exercise_csr(VecCsrBase + 12'd1, 32'h0000_3fff, 32'd0, "vector 1");
    exercise_csr(EntryCsrBase + 12'd2, 32'h0000_001f, 32'h0000_0002, "entry 2");
    exercise_csr(MIntThreshAddr, 32'h0000_0007, 32'd0, "threshold");
    csr_access(CSR_RW, EntryCsrBase + 12'd2, 32'd0, 5'd0);
    csr_access(CSR_RW, MIntThreshAddr, 32'd0, 5'd0);
    csr_read(StackDepthAddr, rd);
    check_word(rd, 32'd0, "stack depth");
    csr_read(12'h123, rd);
    check_word(rd, 32'd0, "unmapped address");
  endtask

  task automatic test_take();
    word vec;
    word rd;
    vec      = random_vec();
    outer_pc = random_pc();
    csr_access(CSR_RW, VecCsrBase + 12'd3, vec, 5'd0);
    drive_pc(outer_pc);
    check_decision(outer_pc, PC_NORMAL, 1'b0, "pass-through before take");
    csr_access(CSR_RW, EntryCsrBase + 12'd3, entry_val(3'd3, 1'b1, 1'b1), 5'd0);
    @(negedge clk);
    check_decision(vec_target(vec), PC_INTERRUPT, 1'b1, "take of slot 3");
    csr_read(MIntThreshAddr, rd);
    check_word(rd, 32'd3, "threshold after take");
    check_prio(level_out, 3'd1, "level after take");
    csr_read(EntryCsrBase + 12'd3, rd);
    check_word(rd, entry_val(3'd3, 1'b1, 1'b0), "slot 3 entry after take");
  endtask

  task automatic test_mask_nest();
    word vec;
    word rd;
    vec      = random_vec();
    inner_pc = random_pc();
    drive_pc(inner_pc);
    csr_access(CSR_RW, EntryCsrBase + 12'd4, entry_val(3'd2, 1'b1, 1'b1), 5'd0);
    @(negedge clk);
    check_decision(inner_pc, PC_NORMAL, 1'b0, "priority 2 under threshold 3");
    csr_access(CSR_RW, VecCsrBase + 12'd5, vec, 5'd0);
    csr_access(CSR_RW, EntryCsrBase + 12'd5, entry_val(3'd5, 1'b1, 1'b1), 5'd0);
    @(negedge clk);
    check_decision(vec_target(vec), PC_INTERRUPT, 1'b1, "nested take of slot 5");
    csr_read(MIntThreshAddr, rd);
    check_word(rd, 32'd5, "threshold after nested take");
    check_prio(level_out, 3'd2, "level after nested take");
  endtask

  task automatic test_return_chain();
    word        vec;
    word        rd;
    imem_addr_t resume_pc;
    resume_pc = random_pc();
    drive_pc(RetMarker);
    check_decision(inner_pc, PC_INTERRUPT, 1'b0, "return from slot 5");
    drive_pc(resume_pc);
    check_prio(level_out, 3'd1, "level after return");
    check_decision(resume_pc, PC_NORMAL, 1'b0, "resumed code");
    csr_read(MIntThreshAddr, rd);
    check_word(rd, 32'd3, "threshold restored by return");
    // equal priority waits for the return, then chains
    vec = random_vec();
    csr_access(CSR_RW, VecCsrBase + 12'd6, vec, 5'd0);
    csr_access(CSR_RW, EntryCsrBase + 12'd6, entry_val(3'd3, 1'b1, 1'b1), 5'd0);
    @(negedge clk);
    check_decision(resume_pc, PC_NORMAL, 1'b0, "priority equal to threshold");
    drive_pc(RetMarker);
    check_decision(vec_target(vec), PC_INTERRUPT, 1'b1, "tail-chain to slot 6");
    drive_pc(resume_pc);
    check_prio(level_out, 3'd1, "level after tail-chain");
    csr_read(EntryCsrBase + 12'd6, rd);
    check_word(rd, entry_val(3'd3, 1'b1, 1'b0), "slot 6 entry after tail-chain");
    csr_read(MIntThreshAddr, rd);
    check_word(rd, 32'd3, "threshold after tail-chain");
    // drop slot 4 so the outer return lands in plain code
    csr_access(CSR_RW, EntryCsrBase + 12'd4, 32'd0, 5'd0);
    drive_pc(RetMarker);
    check_decision(outer_pc, PC_INTERRUPT, 1'b0, "return from slot 3");
    drive_pc(resume_pc);
    check_prio(level_out, 3'd0, "level after outer return");
    csr_read(MIntThreshAddr, rd);
    check_word(rd, 32'd0, "threshold after outer return");
  endtask

  task automatic test_timer();
    word vec;
    word rd;
    int  waited;
    vec = random_vec();
    csr_access(CSR_RW, VecCsrBase, vec, 5'd0);
    csr_access(CSR_RW, TimerAddr, TimerPeriod, 5'd0);
    csr_read(TimerAddr, rd);
    check_word(rd, TimerPeriod, "timer period");
    // cycles since the period write took hold
    waited = 1;
    rd     = 32'd0;
    while (rd[0] !== 1'b1) begin
      if (waited >= TimerPeriod + 2) begin
        $display("Timer did not pend slot 0 within %0d cycles", TimerPeriod + 2);
        $display("Simulation failed");
        $fatal(1, "timer pend missing");
      end
      csr_read(EntryCsrBase, rd);
      waited++;
    end
    check_word(rd, entry_val(3'd0, 1'b0, 1'b1), "slot 0 entry pended by timer");
    csr_access(CSR_RW, TimerAddr, 32'd0, 5'd0);
    // enable slot 0 at priority 4 and keep its pend bit
    csr_access(CSR_RSI, EntryCsrBase, 32'd0, 5'b10010);
    @(negedge clk);
    check_decision(vec_target(vec), PC_INTERRUPT, 1'b1, "take of timer slot 0");
    csr_read(MIntThreshAddr, rd);
    check_word(rd, 32'd4, "threshold after timer take");
    check_prio(level_out, 3'd1, "level after timer take");
    csr_read(EntryCsrBase, rd);
    check_word(rd, entry_val(3'd4, 1'b1, 1'b0), "slot 0 entry after timer take");
  endtask

  initial begin
    seed    = 32'h9786;
    reset   = 1'b1;
    csr_req = '0;
    pc_in   = 16'h0100;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_decision(16'h0100, PC_NORMAL, 1'b0, "after reset");
    check_prio(level_out, 3'd0, "level after reset");
    test_csr_ops();
    test_take();
    test_mask_nest();
    test_return_chain();
    test_timer();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
